// ==== include/host_soc_cfg.svh ====
/*
  Build-time constants of the host subsystem.
  Region bases must be aligned to their length, because targets take
  the word offset from the low address bits only.
  The CLINT offsets are 16 bits wide and relative to CLINT_BASE.
*/
`ifndef HOST_SOC_CFG_SVH
`define HOST_SOC_CFG_SVH

// ------------------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------------------
`define HOST_ADDR_W 32
`define HOST_DATA_W 32

// ------------------------------------------------------------------------
// Memory map
// ------------------------------------------------------------------------
`define ROM_BASE  32'h0001_0000
`define ROM_LEN   32'h0000_0040
`define ROM_WORDS 16

`define CLINT_BASE 32'h0200_0000
`define CLINT_LEN  32'h0000_C000

// CLINT register offsets
`define CLINT_MSIP_OFS        16'h0000
`define CLINT_MTIMECMP_LO_OFS 16'h4000
`define CLINT_MTIMECMP_HI_OFS 16'h4004
`define CLINT_MTIME_LO_OFS    16'hBFF8
`define CLINT_MTIME_HI_OFS    16'hBFFC

// ------------------------------------------------------------------------
// Misc
// ------------------------------------------------------------------------
`define RTC_SYNC_STAGES 2

// Lets the core run its boot code before a debug request can land
`define DBG_DELAY_CYCLES 500

`endif

// ==== verilog/host_soc_pkg.sv ====
/*
  Bus types and boot ROM image shared by the host subsystem.
  One requester, one outstanding transaction, word accesses only.
*/
`include "host_soc_cfg.svh"

package host_soc_pkg;

  typedef struct packed {
    logic                    we;
    logic [`HOST_ADDR_W-1:0] addr;
    logic [`HOST_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [`HOST_DATA_W-1:0] rdata;
    logic                    err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_CLINT = 2'd1,
    TGT_NONE  = 2'd2
  } target_e;

  // Boot image, word 0 at ROM_BASE
  localparam logic [`ROM_WORDS-1:0][`HOST_DATA_W-1:0] ROM_TABLE = {
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'hffdf_f06f, 32'h1050_0073,
    32'h0385_8593, 32'h0000_0597, 32'hf140_2573, 32'h0000_0297
  };

endpackage

// ==== verilog/bus_decoder.sv ====
/*
  Single-requester address decoder with a four-phase req/ack handshake.
  The target and payload are latched when req rises, so the payload must
  stay stable until ack. Unmapped addresses are acked here one cycle
  after req, with err set and rdata zero.
*/
`include "host_soc_cfg.svh"

module bus_decoder
  import host_soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     req_i,
  input  bus_req_t req_data_i,
  output logic     ack_o,
  output bus_rsp_t rsp_o,
  output logic     rom_req_o,
  output bus_req_t rom_data_o,
  input  logic     rom_ack_i,
  input  bus_rsp_t rom_rsp_i,
  output logic     clint_req_o,
  output bus_req_t clint_data_o,
  input  logic     clint_ack_i,
  input  bus_rsp_t clint_rsp_i
);

  localparam bus_rsp_t ERR_RSP = '{rdata: '0, err: 1'b1};

  target_e  tgt_d, tgt_q;
  logic     fwd_req_q;
  logic     err_ack_q;
  bus_req_t data_q;

  function automatic target_e decode_addr(input logic [`HOST_ADDR_W-1:0] addr);
    target_e tgt;
    tgt = TGT_NONE;
    if (addr >= `ROM_BASE && addr < `ROM_BASE + `ROM_LEN) begin
      tgt = TGT_ROM;
    end else if (addr >= `CLINT_BASE && addr < `CLINT_BASE + `CLINT_LEN) begin
      tgt = TGT_CLINT;
    end
    return tgt;
  endfunction

  // Keep the latched target for the rest of the transaction
  assign tgt_d = fwd_req_q ? tgt_q : decode_addr(req_data_i.addr);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      fwd_req_q <= 1'b0;
      err_ack_q <= 1'b0;
      tgt_q     <= TGT_NONE;
    end else begin
      fwd_req_q <= req_i;
      err_ack_q <= req_i && (tgt_d == TGT_NONE);
      if (req_i && !fwd_req_q) begin
        tgt_q <= tgt_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !fwd_req_q) begin
      data_q <= req_data_i;
    end
  end

  assign rom_req_o    = fwd_req_q && (tgt_q == TGT_ROM);
  assign clint_req_o  = fwd_req_q && (tgt_q == TGT_CLINT);
  assign rom_data_o   = data_q;
  assign clint_data_o = data_q;

  // Return path is combinational
  always_comb begin
    case (tgt_q)
      TGT_ROM: begin
        ack_o = rom_ack_i;
        rsp_o = rom_rsp_i;
      end
      TGT_CLINT: begin
        ack_o = clint_ack_i;
        rsp_o = clint_rsp_i;
      end
      default: begin
        ack_o = err_ack_q;
        rsp_o = ERR_RSP;
      end
    endcase
  end

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $rose(ack_o) |-> $past(req_i));

  // A target finishes its handshake before another one is started
  a_one_target: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !((rom_req_o || rom_ack_i) && (clint_req_o || clint_ack_i)));

endmodule

// ==== verilog/boot_rom.sv ====
/*
  Boot ROM behind a four-phase slave port.
  Ack follows req by one cycle and is held until req falls.
  Writes change nothing and are answered with err set.
  The word index comes from the low address bits only.
*/
`include "host_soc_cfg.svh"

module boot_rom
  import host_soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     req_i,
  input  bus_req_t req_data_i,
  output logic     ack_o,
  output bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`ROM_WORDS);

  logic             ack_q;
  logic [IDX_W-1:0] word_idx;
  bus_rsp_t         rsp_q;

  assign word_idx = req_data_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  // Response is captured once and held for the whole ack phase
  always_ff @(posedge clk_i) begin
    if (req_i && !ack_q) begin
      if (req_data_i.we) begin
        rsp_q <= '{rdata: '0, err: 1'b1};
      end else begin
        rsp_q <= '{rdata: ROM_TABLE[word_idx], err: 1'b0};
      end
    end
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

endmodule

// ==== verilog/clint_timer.sv ====
/*
  Core-local interruptor: msip, mtimecmp and a 64-bit mtime.
  rtc_i is asynchronous; mtime steps once every two rising edges of it,
  so rtc_i must stay at each level for more than two clock cycles.
  Accesses are 32 bits wide. Unknown offsets are acked with err set.
*/
`include "host_soc_cfg.svh"

module clint_timer
  import host_soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     rtc_i,
  input  logic     req_i,
  input  bus_req_t req_data_i,
  output logic     ack_o,
  output bus_rsp_t rsp_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic [`RTC_SYNC_STAGES-1:0] rtc_sync_q;
  logic                        rtc_prev_q;
  logic                        rtc_div_q;
  logic                        rtc_rise;
  logic                        mtime_tick;

  logic                    ack_q;
  logic                    access;
  logic [15:0]             ofs;
  logic [`HOST_DATA_W-1:0] rd_val;
  logic                    known;
  logic                    msip_q;
  logic [63:0]             mtime_q;
  logic [63:0]             mtimecmp_q;
  bus_rsp_t                rsp_q;

  // ------------------------------------------------------------------------
  // Real-time input, synchronized and divided by two
  // ------------------------------------------------------------------------
  assign rtc_rise   = rtc_sync_q[`RTC_SYNC_STAGES-1] && !rtc_prev_q;
  assign mtime_tick = rtc_rise && !rtc_div_q;

  // ------------------------------------------------------------------------
  // Register access
  // ------------------------------------------------------------------------
  assign access = req_i && !ack_q;
  assign ofs    = req_data_i.addr[15:0];

  always_comb begin
    known  = 1'b1;
    rd_val = '0;
    case (ofs)
      `CLINT_MSIP_OFS:        rd_val = {{(`HOST_DATA_W-1){1'b0}}, msip_q};
      `CLINT_MTIMECMP_LO_OFS: rd_val = mtimecmp_q[31:0];
      `CLINT_MTIMECMP_HI_OFS: rd_val = mtimecmp_q[63:32];
      `CLINT_MTIME_LO_OFS:    rd_val = mtime_q[31:0];
      `CLINT_MTIME_HI_OFS:    rd_val = mtime_q[63:32];
      default:                known  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
      ack_q      <= 1'b0;
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      rtc_sync_q <= {rtc_sync_q[`RTC_SYNC_STAGES-2:0], rtc_i};
      rtc_prev_q <= rtc_sync_q[`RTC_SYNC_STAGES-1];
      if (rtc_rise) begin
        rtc_div_q <= !rtc_div_q;
      end
      if (mtime_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      ack_q <= req_i;
      // A bus write beats a tick in the same cycle
      if (access && req_data_i.we) begin
        case (ofs)
          `CLINT_MSIP_OFS:        msip_q             <= req_data_i.wdata[0];
          `CLINT_MTIMECMP_LO_OFS: mtimecmp_q[31:0]   <= req_data_i.wdata;
          `CLINT_MTIMECMP_HI_OFS: mtimecmp_q[63:32]  <= req_data_i.wdata;
          `CLINT_MTIME_LO_OFS:    mtime_q[31:0]      <= req_data_i.wdata;
          `CLINT_MTIME_HI_OFS:    mtime_q[63:32]     <= req_data_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rsp_q <= '{rdata: req_data_i.we ? '0 : rd_val, err: !known};
    end
  end

  assign ack_o       = ack_q;
  assign rsp_o       = rsp_q;
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

  // Decoder must hold the payload for the whole request phase
  a_payload_stable: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (req_i && $past(req_i)) |-> $stable(req_data_i));

endmodule

// ==== verilog/debug_gate.sv ====
/*
  Holds the debug request low for DBG_DELAY_CYCLES after reset,
  then passes it through one register stage.
*/
`include "host_soc_cfg.svh"

module debug_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int CNT_W = $clog2(`DBG_DELAY_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             dbg_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CNT_W'(`DBG_DELAY_CYCLES);
      dbg_q <= 1'b0;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      dbg_q <= (cnt_q == '0) && debug_req_i;
    end
  end

  assign debug_req_o = dbg_q;

endmodule

// ==== verilog/host_subsystem.sv ====
/*
  Host subsystem top: decoder, boot ROM, CLINT and debug gate.
  One four-phase requester; request to ack takes at most 3 cycles.
  rtc_i and debug_req_i may be asynchronous to clk_i.
*/
module host_subsystem
  import host_soc_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  logic     rtc_i,
  input  logic     req_i,
  input  bus_req_t req_data_i,
  output logic     ack_o,
  output bus_rsp_t rsp_o,
  input  logic     debug_req_i,
  output logic     debug_req_o,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic     rom_req, rom_ack;
  logic     clint_req, clint_ack;
  bus_req_t rom_data, clint_data;
  bus_rsp_t rom_rsp, clint_rsp;

  bus_decoder i_bus_decoder (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .req_i        ( req_i      ),
    .req_data_i   ( req_data_i ),
    .ack_o        ( ack_o      ),
    .rsp_o        ( rsp_o      ),
    .rom_req_o    ( rom_req    ),
    .rom_data_o   ( rom_data   ),
    .rom_ack_i    ( rom_ack    ),
    .rom_rsp_i    ( rom_rsp    ),
    .clint_req_o  ( clint_req  ),
    .clint_data_o ( clint_data ),
    .clint_ack_i  ( clint_ack  ),
    .clint_rsp_i  ( clint_rsp  )
  );

  boot_rom i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( rom_req    ),
    .req_data_i ( rom_data   ),
    .ack_o      ( rom_ack    ),
    .rsp_o      ( rom_rsp    )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .req_data_i  ( clint_data  ),
    .ack_o       ( clint_ack   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== bench/tb_host_subsystem.sv ====
/*
  Testbench of the host subsystem, driven by a stim file read from
  bench/host_subsystem_stim.txt; run it from the project root.
  Inputs change on the falling clock edge and outputs are sampled there.
  Debug probes must be listed in rising cycle order.
*/
`include "host_soc_cfg.svh"

module tb_host_subsystem
  import host_soc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam string STIM_FILE   = "bench/host_subsystem_stim.txt";
  localparam int    ACK_TIMEOUT = 10;

  logic     clk_i;
  logic     ndmreset_n;
  logic     rtc_i;
  logic     req_i;
  bus_req_t req_data_i;
  logic     ack_o;
  bus_rsp_t rsp_o;
  logic     debug_req_i;
  logic     debug_req_o;
  logic     timer_irq_o;
  logic     ipi_o;

  int          mismatch_cnt = 0;
  int          other_cnt    = 0;
  int          line_cnt     = 0;
  int          cyc          = 0;
  logic        stim_counted = 1'b0;
  logic [31:0] rng_state;

  host_subsystem uut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .req_data_i  ( req_data_i  ),
    .ack_o       ( ack_o       ),
    .rsp_o       ( rsp_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial clk_i = 1'b0;
  always #2 clk_i = !clk_i;

  // Cycles since reset release
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // --------------------------------------------------------------------------
  // Four-phase bus access, starts and ends on a falling edge
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output bus_rsp_t rsp);
    int waited;
    req_data_i = '{we: we, addr: addr, wdata: wdata};
    req_i      = 1'b1;
    waited     = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (ack_o !== 1'b1 && waited < ACK_TIMEOUT);
    if (ack_o !== 1'b1) begin
      other_cnt++;
      $display("Bus request to %h got no ack within %0d cycles", addr, ACK_TIMEOUT);
    end
    rsp    = rsp_o;
    req_i  = 1'b0;
    waited = 0;
    while (ack_o !== 1'b0 && waited < ACK_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (ack_o !== 1'b0) begin
      other_cnt++;
      $display("Ack for address %h did not fall after req was dropped", addr);
    end
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) @(negedge clk_i);
  endtask

  task automatic rtc_pulses(input int n);
    repeat (n) begin
      rtc_i = 1'b1;
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (4) @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
  endtask

  task automatic debug_probe(input int at_cyc, input logic val, input logic exp);
    while (cyc < at_cyc) @(negedge clk_i);
    if (cyc > at_cyc) begin
      other_cnt++;
      $display("Debug probe for cycle %0d came late, at cycle %0d", at_cyc, cyc);
    end
    debug_req_i = val;
    repeat (2) @(negedge clk_i);
    check_value("debug_req_o", exp, debug_req_o);
  endtask

  task automatic run_stim(input int fd);
    string       line;
    byte         cmd;
    logic [31:0] addr;
    logic [31:0] data;
    int          a, b, c;
    int          n;
    bus_rsp_t    rsp;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      n = $sscanf(line, "%c", cmd);
      case (cmd)
        "R": begin
          n = $sscanf(line, "R %h %h %d", addr, data, a);
          bus_access(1'b0, addr, 32'h0, rsp);
          check_value("rsp_o.rdata", data, rsp.rdata);
          check_value("rsp_o.err", a, rsp.err);
        end
        "W": begin
          n = $sscanf(line, "W %h %h %d", addr, data, a);
          bus_access(1'b1, addr, data, rsp);
          check_value("rsp_o.err", a, rsp.err);
        end
        "T": begin
          n = $sscanf(line, "T %d", a);
          rtc_pulses(a);
        end
        "D": begin
          n = $sscanf(line, "D %d %d %d", a, b, c);
          debug_probe(a, b[0], c[0]);
        end
        "I": begin
          n = $sscanf(line, "I %d %d", a, b);
          check_value("timer_irq_o", a, timer_irq_o);
          check_value("ipi_o", b, ipi_o);
        end
        default: begin
          other_cnt++;
          $display("Unknown command in stim line: %s", line);
        end
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int    fd;
    string line;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    req_i       = 1'b0;
    req_data_i  = '0;
    debug_req_i = 1'b0;
    rng_state   = 32'hcb901095;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stim file %s", STIM_FILE);
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          line_cnt++;
        end
      end
      $fclose(fd);
      stim_counted = 1'b1;
      repeat (5) @(negedge clk_i);
      ndmreset_n = 1'b1;
      @(negedge clk_i);
      fd = $fopen(STIM_FILE, "r");
      run_stim(fd);
      $fclose(fd);
      repeat (4) @(negedge clk_i);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  // Budget of 64 cycles per stim line on top of the debug hold-off
  initial begin
    wait (stim_counted);
    repeat (line_cnt * 64 + `DBG_DELAY_CYCLES + 100) @(posedge clk_i);
    $display("Watchdog expired before the stim file was done");
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== bench/host_subsystem_stim.txt ====
# R addr rdata err | W addr wdata err | T rtc_rising_edges | I timer_irq ipi
# D cycle debug_req_i expected_debug_req_o   (addr and data hex, the rest decimal)
D 10 1 0
I 0 0
R 00010000 00000297 0
R 00010004 f1402573 0
R 00010014 ffdff06f 0
R 0001003c 00000013 0
W 00010004 deadbeef 1
R 00010004 f1402573 0
R 00010040 00000000 1
R 00000000 00000000 1
W 30000000 12345678 1
R 02000100 00000000 1
W 02000000 00000001 0
I 0 1
R 02000000 00000001 0
W 02000000 00000000 0
I 0 0
R 02000000 00000000 0
W 0200bff8 00000064 0
W 02004000 00000032 0
W 02004004 00000000 0
I 1 0
W 02004000 ffffffff 0
W 02004004 ffffffff 0
I 0 0
W 0200bff8 00001000 0
W 0200bffc 00000000 0
R 0200bff8 00001000 0
T 6
R 0200bff8 00001003 0
R 0200bffc 00000000 0
D 600 1 1
D 605 0 0

// ==== build.f ====
+incdir+include
verilog/host_soc_pkg.sv
verilog/bus_decoder.sv
verilog/boot_rom.sv
verilog/clint_timer.sv
verilog/debug_gate.sv
verilog/host_subsystem.sv
bench/tb_host_subsystem.sv
